/* all.f */
+incdir+source
source/fir_pkg.sv
source/fir_axil_regs.sv
source/fir_tap_bank.sv
source/fir_out_stage.sv
source/fir_axil_top.sv
dv/fir_assertions.sv
dv/fir_tb.sv

/* dv/fir_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module fir_assertions (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire S_AXI_AWREADY,
	input wire S_AXI_WREADY,
	input wire S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire S_AXI_RVALID,
	input wire S_AXI_RREADY,
	input wire flt_valid,
	input wire flt_out_valid
);

	int fail_count = 0; // tally of failed assertions

	// responses stay up until taken
	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else begin
			$error("BVALID dropped before BREADY");
			fail_count++;
		end

	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
		else begin
			$error("RVALID dropped before RREADY");
			fail_count++;
		end

	ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY == S_AXI_WREADY)
		else begin
			$error("AWREADY and WREADY differ");
			fail_count++;
		end

	// pipeline depth, checked once reset is three edges back
	out_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$past(S_AXI_ARESETN, 3) |-> flt_out_valid == $past(flt_valid, 3))
		else begin
			$error("flt_out_valid is not flt_valid delayed by 3 cycles");
			fail_count++;
		end

endmodule

bind fir_axil_top fir_assertions assert_inst (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.S_AXI_AWREADY(S_AXI_AWREADY),
	.S_AXI_WREADY(S_AXI_WREADY),
	.S_AXI_BVALID(S_AXI_BVALID),
	.S_AXI_BREADY(S_AXI_BREADY),
	.S_AXI_RVALID(S_AXI_RVALID),
	.S_AXI_RREADY(S_AXI_RREADY),
	.flt_valid(flt_valid),
	.flt_out_valid(flt_out_valid)
);

`default_nettype wire

/* dv/fir_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_tb;

	localparam int wait_limit = 100; // cycles any single wait may take
	localparam int sat_hi = (1 << (`FIR_DATA_WIDTH - 1)) - 1;
	localparam int sat_lo = -(1 << (`FIR_DATA_WIDTH - 1));

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	logic [`FIR_AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
	logic [`FIR_AXI_DATA_WIDTH-1:0] S_AXI_WDATA;
	logic S_AXI_AWVALID, S_AXI_WVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_RREADY;
	wire S_AXI_AWREADY, S_AXI_WREADY, S_AXI_BVALID, S_AXI_ARREADY, S_AXI_RVALID;
	wire [1:0] S_AXI_BRESP, S_AXI_RRESP;
	wire fir_pkg::axi_data_t S_AXI_RDATA;
	fir_pkg::sample_t flt_in;
	logic flt_valid;
	wire fir_pkg::sample_t flt_out;
	wire flt_out_valid;
	wire [7:0] leds;

	int coef_model [`FIR_TAPS];
	int hist [`FIR_TAPS]; // hist[k] holds x[n-k]
	int exp_q [$]; // predicted outputs still in flight
	bit filt_on; // mirror of the enable switch
	int value_errors;
	int timeout_errors;
	int sat_hits; // outputs the model had to clip
	logic [31:0] lfsr = 32'h179d62e0;

	fir_axil_top fir_axil_top_inst (.*);

	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	// outputs settle well before the falling edge
	always @(negedge S_AXI_ACLK) begin
		if (flt_out_valid)
			expect_out();
	end

	// galois lfsr, one step for every bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hd0000001 : lfsr >> 1;
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int rand_signed(input int n);
		logic [31:0] r;
		r = rand_bits(n);
		return $signed(r << (32 - n)) >>> (32 - n); // sign extend from bit n-1
	endfunction

	// shift the history, then apply the filter rule or pass the sample
	function automatic int predict(input int x);
		longint acc;
		for (int k = `FIR_TAPS - 1; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = x;
		if (!filt_on)
			return x;
		acc = 0;
		for (int k = 0; k < `FIR_TAPS; k++)
			acc += longint'(coef_model[k]) * longint'(hist[k]);
		acc = acc >>> `FIR_COEF_MAG;
		if (acc > sat_hi || acc < sat_lo)
			sat_hits++;
		if (acc > sat_hi)
			return sat_hi;
		if (acc < sat_lo)
			return sat_lo;
		return int'(acc);
	endfunction

	task automatic report_mismatch(input string name, input longint exp_v, input longint act_v);
		value_errors++;
		$display("Fail at time %0t: %s expected %0d (0x%0h) got %0d (0x%0h)",
			$time, name, exp_v, exp_v, act_v, act_v);
	endtask

	task automatic note_timeout(input string what);
		timeout_errors++;
		$display("Timeout at time %0t while waiting for %s", $time, what);
	endtask

	task automatic axi_write(input int word, input logic [31:0] data);
		int n;
		@(negedge S_AXI_ACLK);
		flt_valid = 1'b0;
		S_AXI_AWADDR = 8'(word << `FIR_ADDR_LSB);
		S_AXI_WDATA = data;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID = 1'b1;
		n = 0;
		while (!S_AXI_AWREADY && n < wait_limit) begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n == wait_limit)
			note_timeout("S_AXI_AWREADY");
		@(negedge S_AXI_ACLK); // handshake taken on the edge between
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		n = 0;
		while (!S_AXI_BVALID && n < wait_limit) begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n == wait_limit)
			note_timeout("S_AXI_BVALID");
		if (S_AXI_BRESP !== 2'b00)
			report_mismatch("S_AXI_BRESP", 0, S_AXI_BRESP);
		S_AXI_BREADY = 1'b1;
		@(negedge S_AXI_ACLK);
		S_AXI_BREADY = 1'b0;
	endtask

	task automatic axi_read(input int word, output logic [31:0] data, output logic [1:0] resp);
		int n;
		@(negedge S_AXI_ACLK);
		flt_valid = 1'b0;
		S_AXI_ARADDR = 8'(word << `FIR_ADDR_LSB);
		S_AXI_ARVALID = 1'b1;
		n = 0;
		while (!S_AXI_ARREADY && n < wait_limit) begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n == wait_limit)
			note_timeout("S_AXI_ARREADY");
		@(negedge S_AXI_ACLK);
		S_AXI_ARVALID = 1'b0;
		n = 0;
		while (!S_AXI_RVALID && n < wait_limit) begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n == wait_limit)
			note_timeout("S_AXI_RVALID");
		data = S_AXI_RDATA;
		resp = S_AXI_RRESP;
		S_AXI_RREADY = 1'b1;
		@(negedge S_AXI_ACLK);
		S_AXI_RREADY = 1'b0;
	endtask

	task automatic read_expect(input int word, input logic [31:0] exp_v);
		logic [31:0] d;
		logic [1:0] r;
		axi_read(word, d, r);
		if (d !== exp_v)
			report_mismatch("S_AXI_RDATA", longint'(exp_v), longint'(d));
		if (r !== 2'b00)
			report_mismatch("S_AXI_RRESP", 0, longint'(r));
	endtask

	task automatic send_sample(input int x);
		@(negedge S_AXI_ACLK);
		flt_in = fir_pkg::sample_t'(x);
		flt_valid = 1'b1; // stays high if the next call follows at once
		exp_q.push_back(predict(x));
	endtask

	task automatic hold_idle(input int cycles);
		repeat (cycles) begin
			@(negedge S_AXI_ACLK);
			flt_valid = 1'b0;
		end
	endtask

	task automatic expect_out();
		int e;
		if (exp_q.size() == 0) begin
			value_errors++;
			$display("Unexpected flt_out_valid at time %0t with no sample in flight", $time);
		end else begin
			e = exp_q.pop_front();
			if (flt_out !== fir_pkg::sample_t'(e))
				report_mismatch("flt_out", e, flt_out);
		end
	endtask

	task automatic drain_outputs();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < wait_limit) begin
			@(negedge S_AXI_ACLK);
			flt_valid = 1'b0;
			n++;
		end
		if (exp_q.size() != 0)
			note_timeout("remaining flt_out_valid pulses");
	endtask

	task automatic read_identity_words();
		read_expect(`FIR_REG_NAME, " RIF");
		read_expect(`FIR_REG_VER, "01.3");
		read_expect(`FIR_REG_STAT, "VED ");
		read_expect(`FIR_REG_TAPS, 32'd8);
		read_expect(`FIR_REG_COEF_MAG, 32'd17);
		axi_write(3, 32'hffff_ffff); // nothing behind this word
		read_expect(3, 32'd0); // hole in the map
	endtask

	task automatic switch_readback();
		axi_write(`FIR_REG_SWITCHES, 32'h5a5a_c3a5); // bit 1 clear, stays in bypass
		read_expect(`FIR_REG_SWITCHES, 32'h5a5a_c3a5);
		if (leds !== 8'ha5)
			report_mismatch("leds", 8'ha5, leds);
	endtask

	task automatic bypass_after_reset();
		if (leds !== 8'h00) // switches clear out of reset
			report_mismatch("leds", 0, leds);
		repeat (24)
			send_sample(rand_signed(`FIR_DATA_WIDTH));
		drain_outputs();
	endtask

	task automatic load_coefs();
		int c;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			c = rand_signed(`FIR_COEF_WIDTH);
			coef_model[k] = c;
			axi_write(`FIR_COEF_BASE + k, 32'(c)); // sign lands in bit 31
		end
		read_expect(`FIR_COEF_BASE + 2, 32'd0); // write-only window
	endtask

	task automatic impulse_response();
		int amp;
		axi_write(`FIR_REG_SWITCHES, 32'h0000_0002);
		filt_on = 1'b1;
		amp = rand_signed(`FIR_DATA_WIDTH);
		repeat (`FIR_TAPS)
			send_sample(0); // flush the bypass history
		send_sample(amp);
		repeat (`FIR_TAPS)
			send_sample(0);
		drain_outputs();
	endtask

	task automatic filtered_stream();
		sat_hits = 0;
		repeat (48)
			send_sample(rand_signed(`FIR_DATA_WIDTH));
		repeat (48) begin
			send_sample(rand_signed(`FIR_DATA_WIDTH));
			hold_idle(int'(rand_bits(2))); // gaps of 0 to 3 cycles
		end
		repeat (16)
			send_sample(rand_bits(1) ? sat_hi : sat_lo); // full scale
		drain_outputs();
		if (sat_hits == 0) begin
			value_errors++;
			$display("Stream at time %0t never drove the output into saturation", $time);
		end
	endtask

	task automatic coef_rewrite();
		int c;
		repeat (12)
			send_sample(rand_signed(`FIR_DATA_WIDTH));
		c = rand_signed(`FIR_COEF_WIDTH);
		axi_write(`FIR_COEF_BASE + 5, 32'(c)); // older samples leave the banks first
		coef_model[5] = c;
		repeat (12)
			send_sample(rand_signed(`FIR_DATA_WIDTH));
		drain_outputs();
	endtask

	initial begin
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_ARADDR = '0;
		S_AXI_WDATA = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		flt_in = '0;
		flt_valid = 1'b0;
		repeat (5) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		read_identity_words();
		bypass_after_reset();
		switch_readback();
		load_coefs();
		impulse_response();
		filtered_stream();
		coef_rewrite();
		$display("errors: %0d value, %0d timeout, %0d assertion", value_errors,
			timeout_errors, fir_axil_top_inst.assert_inst.fail_count);
		if (value_errors + timeout_errors + fir_axil_top_inst.assert_inst.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the FIR testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f all.f --top-module fir_tb -o fir_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed, see build.log"
	exit 1
fi

# keep running past assertion errors so the testbench can count them
./obj_dir/fir_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* source/fir_axil_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_axil_regs (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire [`FIR_AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire [`FIR_AXI_DATA_WIDTH-1:0] S_AXI_WDATA,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output wire [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire [`FIR_AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output fir_pkg::axi_data_t S_AXI_RDATA,
	output wire [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	output wire [7:0] leds,
	output wire fir_en,
	output logic coef_wr_en,
	output fir_pkg::tap_idx_t coef_wr_idx,
	output fir_pkg::coef_t coef_wr_data
);

	fir_pkg::wr_state_t wr_state;
	fir_pkg::rd_state_t rd_state;

	fir_pkg::word_addr_t wr_word; // word address of the write
	fir_pkg::word_addr_t rd_word;
	fir_pkg::word_addr_t coef_off; // offset into the coefficient window
	fir_pkg::axi_data_t switches;
	fir_pkg::axi_data_t rd_mux;

	logic wr_fire; // write handshake on this edge
	logic rd_fire;
	logic coef_hit;

	assign S_AXI_BRESP = 2'b00; // always OKAY
	assign S_AXI_RRESP = 2'b00;

	assign wr_word = S_AXI_AWADDR[`FIR_AXI_ADDR_WIDTH-1:`FIR_ADDR_LSB];
	assign rd_word = S_AXI_ARADDR[`FIR_AXI_ADDR_WIDTH-1:`FIR_ADDR_LSB];

	// both channels presented together, ready pulsed for one cycle
	assign wr_fire = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID;
	assign rd_fire = S_AXI_ARREADY && S_AXI_ARVALID;

	// words below the window wrap past FIR_TAPS and miss
	assign coef_off = wr_word - fir_pkg::word_addr_t'(`FIR_COEF_BASE);
	assign coef_hit = coef_off < fir_pkg::word_addr_t'(`FIR_TAPS);

	assign leds = switches[7:0];
	assign fir_en = switches[`FIR_SWITCH_EN]; // low means bypass

	// write channel FSM
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_state <= fir_pkg::wr_idle;
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			S_AXI_BVALID <= 1'b0;
		end else begin
			case (wr_state)
				fir_pkg::wr_idle: begin
					if (wr_fire) begin
						S_AXI_AWREADY <= 1'b0; // end of the ready pulse
						S_AXI_WREADY <= 1'b0;
						S_AXI_BVALID <= 1'b1;
						wr_state <= fir_pkg::wr_resp;
					end else if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID) begin
						S_AXI_AWREADY <= 1'b1;
						S_AXI_WREADY <= 1'b1;
					end else begin
						S_AXI_AWREADY <= 1'b0;
						S_AXI_WREADY <= 1'b0;
					end
				end
				fir_pkg::wr_resp: begin
					if (S_AXI_BREADY) begin // response taken
						S_AXI_BVALID <= 1'b0;
						wr_state <= fir_pkg::wr_idle;
					end
				end
				default: wr_state <= fir_pkg::wr_idle;
			endcase
		end
	end

	// switch register and the coefficient strobe
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
			coef_wr_en <= 1'b0;
		end else begin
			coef_wr_en <= wr_fire && coef_hit; // single cycle
			if (wr_fire && wr_word == fir_pkg::word_addr_t'(`FIR_REG_SWITCHES))
				switches <= S_AXI_WDATA; // full word, no strobes
		end
	end

	// index and value ride along with the strobe
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_fire) begin
			coef_wr_idx <= fir_pkg::tap_idx_t'(coef_off);
			// sign from the top bit, magnitude bits from the bottom
			coef_wr_data <= {S_AXI_WDATA[`FIR_AXI_DATA_WIDTH-1],
				S_AXI_WDATA[`FIR_COEF_WIDTH-2:0]};
		end
	end

	// read channel FSM
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rd_state <= fir_pkg::rd_idle;
			S_AXI_ARREADY <= 1'b0;
			S_AXI_RVALID <= 1'b0;
		end else begin
			case (rd_state)
				fir_pkg::rd_idle: begin
					if (rd_fire) begin
						S_AXI_ARREADY <= 1'b0;
						S_AXI_RVALID <= 1'b1; // data follows the handshake
						rd_state <= fir_pkg::rd_data;
					end else if (!S_AXI_ARREADY && S_AXI_ARVALID) begin
						S_AXI_ARREADY <= 1'b1;
					end else begin
						S_AXI_ARREADY <= 1'b0;
					end
				end
				fir_pkg::rd_data: begin
					if (S_AXI_RREADY) begin
						S_AXI_RVALID <= 1'b0;
						rd_state <= fir_pkg::rd_idle;
					end
				end
				default: rd_state <= fir_pkg::rd_idle;
			endcase
		end
	end

	// read decode, coefficient window is write-only
	always_comb begin
		case (rd_word)
			fir_pkg::word_addr_t'(`FIR_REG_NAME): rd_mux = `FIR_ID_NAME;
			fir_pkg::word_addr_t'(`FIR_REG_VER): rd_mux = `FIR_ID_VER;
			fir_pkg::word_addr_t'(`FIR_REG_STAT): rd_mux = `FIR_ID_STAT;
			fir_pkg::word_addr_t'(`FIR_REG_TAPS): rd_mux = fir_pkg::axi_data_t'(`FIR_TAPS);
			fir_pkg::word_addr_t'(`FIR_REG_COEF_MAG): rd_mux = fir_pkg::axi_data_t'(`FIR_COEF_MAG);
			fir_pkg::word_addr_t'(`FIR_REG_SWITCHES): rd_mux = switches;
			default: rd_mux = '0; // unmapped
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_fire)
			S_AXI_RDATA <= rd_mux;
	end

endmodule

`default_nettype wire

/* source/fir_axil_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_axil_top (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire [`FIR_AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output wire S_AXI_AWREADY,
	input wire [`FIR_AXI_DATA_WIDTH-1:0] S_AXI_WDATA,
	input wire S_AXI_WVALID,
	output wire S_AXI_WREADY,
	output wire [1:0] S_AXI_BRESP,
	output wire S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire [`FIR_AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output wire S_AXI_ARREADY,
	output wire fir_pkg::axi_data_t S_AXI_RDATA,
	output wire [1:0] S_AXI_RRESP,
	output wire S_AXI_RVALID,
	input wire S_AXI_RREADY,
	input wire fir_pkg::sample_t flt_in,
	input wire flt_valid,
	output wire fir_pkg::sample_t flt_out,
	output wire flt_out_valid,
	output wire [7:0] leds
);

	wire fir_en;
	wire coef_wr_en;
	wire fir_pkg::tap_idx_t coef_wr_idx;
	wire fir_pkg::coef_t coef_wr_data;
	wire fir_pkg::sample_t lo_tail; // chain into the high bank
	wire fir_pkg::bank_sum_t lo_sum;
	wire fir_pkg::bank_sum_t hi_sum;
	wire lo_valid;
	wire hi_valid;
	wire sums_valid;

	assign sums_valid = lo_valid & hi_valid; // banks run in lockstep

	fir_axil_regs regs_inst (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY), .S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP), .S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY), .S_AXI_RDATA(S_AXI_RDATA),
		.S_AXI_RRESP(S_AXI_RRESP), .S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY),
		.leds(leds), .fir_en(fir_en), .coef_wr_en(coef_wr_en),
		.coef_wr_idx(coef_wr_idx), .coef_wr_data(coef_wr_data)
	);

	fir_tap_bank #(.first_tap(0)) bank_lo_inst ( // taps 0..3, takes the raw sample
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.sample_valid(flt_valid), .sample_in(flt_in),
		.coef_wr_en(coef_wr_en), .coef_wr_idx(coef_wr_idx), .coef_wr_data(coef_wr_data),
		.tail_sample(lo_tail), .partial_sum(lo_sum), .sum_valid(lo_valid)
	);

	// taps 4..7, end of the delay line
	fir_tap_bank #(.first_tap(4)) bank_hi_inst (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.sample_valid(flt_valid), .sample_in(lo_tail),
		.coef_wr_en(coef_wr_en), .coef_wr_idx(coef_wr_idx), .coef_wr_data(coef_wr_data),
		.tail_sample(), .partial_sum(hi_sum), .sum_valid(hi_valid)
	);

	fir_out_stage out_inst (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.flt_in(flt_in), .flt_valid(flt_valid), .fir_en(fir_en),
		.low_sum(lo_sum), .high_sum(hi_sum), .sum_valid(sums_valid),
		.flt_out(flt_out), .flt_out_valid(flt_out_valid)
	);

endmodule

`default_nettype wire

/* source/fir_config.svh */
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// axi4-lite geometry, byte addressed
`define FIR_AXI_ADDR_WIDTH 8
`define FIR_AXI_DATA_WIDTH 32
`define FIR_ADDR_LSB 2

`define FIR_DATA_WIDTH 14 // sample width
`define FIR_COEF_WIDTH 18
`define FIR_COEF_MAG 17 // fraction bits of a coefficient
`define FIR_TAPS 8
`define FIR_BANK_TAPS 4

// register word addresses
`define FIR_REG_NAME 0
`define FIR_REG_VER 1
`define FIR_REG_STAT 2
`define FIR_REG_TAPS 4
`define FIR_REG_COEF_MAG 5
`define FIR_REG_SWITCHES 20
`define FIR_COEF_BASE 32 // coefficient window, one word per tap

`define FIR_ID_NAME " RIF" // byte reversed, reads FIR on a little-endian host
`define FIR_ID_VER "01.3"
`define FIR_ID_STAT "VED "
`define FIR_SWITCH_EN 1 // switch bit that enables the filter

`endif

/* source/fir_out_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_out_stage (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire fir_pkg::sample_t flt_in,
	input wire flt_valid,
	input wire fir_en,
	input wire fir_pkg::bank_sum_t low_sum,
	input wire fir_pkg::bank_sum_t high_sum,
	input wire sum_valid,
	output fir_pkg::sample_t flt_out,
	output logic flt_out_valid
);

	// signed limits of a sample in the accumulator width
	localparam fir_pkg::acc_t sat_max = fir_pkg::acc_t'((1 << (`FIR_DATA_WIDTH-1)) - 1);
	localparam fir_pkg::acc_t sat_min = ~sat_max;

	fir_pkg::sample_t byp_d1; // bypass, matches the bank latency
	fir_pkg::sample_t byp_d2;
	fir_pkg::acc_t acc;
	fir_pkg::acc_t scaled;
	fir_pkg::sample_t sat_sample;

	always_comb begin
		acc = low_sum + high_sum;
		scaled = acc >>> `FIR_COEF_MAG; // drop the coefficient fraction
		if (scaled > sat_max)
			sat_sample = {1'b0, {(`FIR_DATA_WIDTH-1){1'b1}}};
		else if (scaled < sat_min)
			sat_sample = {1'b1, {(`FIR_DATA_WIDTH-1){1'b0}}};
		else
			sat_sample = scaled[`FIR_DATA_WIDTH-1:0];
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (flt_valid)
			byp_d1 <= flt_in; // same edge the banks shift
		byp_d2 <= byp_d1;
		flt_out <= fir_en ? sat_sample : byp_d2;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			flt_out_valid <= 1'b0;
		else
			flt_out_valid <= sum_valid;
	end

endmodule

`default_nettype wire

/* source/fir_pkg.sv */
`default_nettype none

`include "fir_config.svh"

package fir_pkg;

	typedef logic [`FIR_AXI_DATA_WIDTH-1:0] axi_data_t; // one register word
	typedef logic [`FIR_AXI_ADDR_WIDTH-`FIR_ADDR_LSB-1:0] word_addr_t;

	typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
	typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;
	typedef logic [$clog2(`FIR_TAPS)-1:0] tap_idx_t;

	// product width plus growth for the four taps of a bank
	typedef logic signed [`FIR_DATA_WIDTH+`FIR_COEF_WIDTH+$clog2(`FIR_BANK_TAPS)-1:0] bank_sum_t;
	// one more bit for adding the two banks
	typedef logic signed [$bits(bank_sum_t):0] acc_t;

	// write channel, response pending or not
	typedef enum logic {wr_idle, wr_resp} wr_state_t;

	typedef enum logic {rd_idle, rd_data} rd_state_t; // read data pending or not

endpackage

`default_nettype wire

/* source/fir_tap_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_tap_bank #(
	parameter int first_tap = 0 // tap number of stage 0
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire sample_valid,
	input wire fir_pkg::sample_t sample_in,
	input wire coef_wr_en,
	input wire fir_pkg::tap_idx_t coef_wr_idx,
	input wire fir_pkg::coef_t coef_wr_data,
	output fir_pkg::sample_t tail_sample,
	output fir_pkg::bank_sum_t partial_sum,
	output logic sum_valid
);

	fir_pkg::coef_t coefs [`FIR_BANK_TAPS];
	fir_pkg::sample_t stages [`FIR_BANK_TAPS]; // stage 0 is the newest

	fir_pkg::tap_idx_t local_idx;
	fir_pkg::bank_sum_t sum_next;
	logic own_tap; // write lands in this bank
	logic shifted; // delay line moved on the last edge

	// taps outside the bank wrap to large offsets
	assign local_idx = coef_wr_idx - fir_pkg::tap_idx_t'(first_tap);
	assign own_tap = local_idx < fir_pkg::tap_idx_t'(`FIR_BANK_TAPS);

	assign tail_sample = stages[`FIR_BANK_TAPS-1]; // feeds the next bank

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < `FIR_BANK_TAPS; i++) begin
				coefs[i] <= '0;
				stages[i] <= '0;
			end
		end else begin
			if (coef_wr_en && own_tap)
				coefs[local_idx[$clog2(`FIR_BANK_TAPS)-1:0]] <= coef_wr_data;
			if (sample_valid) begin
				stages[0] <= sample_in;
				for (int i = 1; i < `FIR_BANK_TAPS; i++)
					stages[i] <= stages[i-1];
			end
		end
	end

	// four products, sign extended to the bank width
	always_comb begin
		sum_next = '0;
		for (int i = 0; i < `FIR_BANK_TAPS; i++)
			sum_next = sum_next + coefs[i] * stages[i];
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			shifted <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			shifted <= sample_valid;
			sum_valid <= shifted; // one edge after the shift
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		partial_sum <= sum_next; // qualified by sum_valid
	end

endmodule

`default_nettype wire
